// File: rtl/sonar_pkg.sv
`default_nettype none

package sonar_pkg;

    // Scaled down for simulation; any value that fits the widths below works
    localparam int TRIG_CYCLES     = 10;    // Trigger pulse length in cycles
    localparam int ECHO_WAIT_LIMIT = 400;   // Sampled edges before giving up on echo

    localparam int ECHO_W          = 12;
    localparam int ECHO_COUNT_MAX  = (2 ** ECHO_W) - 1;   // 4095, echo count saturates here

    // One cycle counter covers both the trigger pulse and the echo wait window
    localparam int CYCLE_SPAN = (ECHO_WAIT_LIMIT > TRIG_CYCLES) ? ECHO_WAIT_LIMIT : TRIG_CYCLES;
    localparam int CYCLE_W    = $clog2(CYCLE_SPAN + 1);

    // Echo duration in clock cycles
    typedef logic [ECHO_W-1:0] echo_count_t;

    typedef logic [CYCLE_W-1:0] cycle_count_t;

    typedef enum logic [2:0] {
        IDLE,        // Waiting for meas_req
        TRIGGER,     // Driving the trigger pulse
        WAIT_ECHO,   // Trigger done, echo not seen yet
        MEASURE,     // Echo high, counting
        DONE         // Results valid, meas_ack high
    } ranger_state_t;

endpackage

`default_nettype wire

// File: rtl/alert_pkg.sv
`default_nettype none

package alert_pkg;

    localparam int NEAR_THRESHOLD = 300;   // Counts below this are near
    localparam int ALARM_ROUNDS   = 3;     // Consecutive near rounds before alarm

    localparam int STREAK_W = 2;

    // Consecutive near rounds, held at ALARM_ROUNDS once reached
    typedef logic [STREAK_W-1:0] streak_t;

    typedef enum logic [1:0] {
        IDLE,      // Waiting for host_req
        RANGING,   // meas_req high, both rangers busy
        REPORT,    // host_ack high until host drops host_req
        RELEASE    // meas_req low, waiting for both acks to drop
    } judge_state_t;

endpackage

`default_nettype wire

// File: rtl/echo_ranger.sv
`timescale 1ns/1ps
`default_nettype none

module echo_ranger (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   meas_req,
    input  logic                   echo,
    output logic                   meas_ack,
    output logic                   trigger,
    output sonar_pkg::echo_count_t echo_count,
    output logic                   timed_out
);

    sonar_pkg::ranger_state_t state;
    sonar_pkg::ranger_state_t state_next;

    sonar_pkg::cycle_count_t cycle_cnt;   // Trigger length, then wait window

    logic trig_last;      // Last cycle of the trigger pulse
    logic wait_expired;   // Final sample of the wait window, still no echo
    logic echo_sat;

    assign trig_last = (cycle_cnt == sonar_pkg::cycle_count_t'(sonar_pkg::TRIG_CYCLES - 1));

    assign wait_expired = !echo &&
        (cycle_cnt == sonar_pkg::cycle_count_t'(sonar_pkg::ECHO_WAIT_LIMIT - 1));

    assign echo_sat = (echo_count == sonar_pkg::echo_count_t'(sonar_pkg::ECHO_COUNT_MAX));

    always_comb begin
        state_next = state;
        case (state)
            sonar_pkg::IDLE: begin
                if (meas_req) begin
                    state_next = sonar_pkg::TRIGGER;
                end
            end
            sonar_pkg::TRIGGER: begin
                if (trig_last) begin
                    state_next = sonar_pkg::WAIT_ECHO;
                end
            end
            sonar_pkg::WAIT_ECHO: begin
                if (echo) begin
                    state_next = sonar_pkg::MEASURE;
                end else if (wait_expired) begin
                    state_next = sonar_pkg::DONE;   // Give up, report a timeout
                end
            end
            sonar_pkg::MEASURE: begin
                if (!echo) begin
                    state_next = sonar_pkg::DONE;
                end
            end
            sonar_pkg::DONE: begin
                // Hold results until the judge releases its request
                if (!meas_req) begin
                    state_next = sonar_pkg::IDLE;
                end
            end
            default: begin
                state_next = sonar_pkg::IDLE;
            end
        endcase
    end

    // Trigger and ack are registered so the pins never glitch
    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= sonar_pkg::IDLE;
            trigger  <= 1'b0;
            meas_ack <= 1'b0;
        end else begin
            state    <= state_next;
            trigger  <= (state_next == sonar_pkg::TRIGGER);
            meas_ack <= (state_next == sonar_pkg::DONE);
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            sonar_pkg::IDLE: begin
                cycle_cnt <= '0;
            end
            sonar_pkg::TRIGGER: begin
                cycle_cnt <= trig_last ? '0 : cycle_cnt + 1'b1;
            end
            sonar_pkg::WAIT_ECHO: begin
                cycle_cnt <= cycle_cnt + 1'b1;
                if (echo) begin
                    echo_count <= sonar_pkg::echo_count_t'(1);   // Detecting edge counts
                    timed_out  <= 1'b0;
                end else if (wait_expired) begin
                    echo_count <= '0;
                    timed_out  <= 1'b1;
                end
            end
            sonar_pkg::MEASURE: begin
                if (echo && !echo_sat) begin
                    echo_count <= echo_count + 1'b1;
                end
            end
            default: begin
                cycle_cnt <= cycle_cnt;   // DONE holds everything
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/proximity_judge.sv
`timescale 1ns/1ps
`default_nettype none

module proximity_judge (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   host_req,
    output logic                   host_ack,
    output logic                   meas_req,
    input  logic                   ack_left,
    input  logic                   ack_right,
    input  sonar_pkg::echo_count_t count_left,
    input  sonar_pkg::echo_count_t count_right,
    input  logic                   timeout_left,
    input  logic                   timeout_right,
    output sonar_pkg::echo_count_t nearest_count,
    output logic                   near_left,
    output logic                   near_right,
    output logic                   alarm
);

    alert_pkg::judge_state_t state;
    alert_pkg::judge_state_t state_next;

    alert_pkg::streak_t streak;
    alert_pkg::streak_t streak_next;

    sonar_pkg::echo_count_t side_left;    // Timeout counts as far away
    sonar_pkg::echo_count_t side_right;
    sonar_pkg::echo_count_t nearest_next;

    logic hit_left;
    logic hit_right;
    logic both_ack;
    logic both_idle;
    logic latch_en;   // Both rangers done, capture the round

    assign both_ack  = ack_left && ack_right;
    assign both_idle = !ack_left && !ack_right;
    assign latch_en  = (state == alert_pkg::RANGING) && both_ack;

    assign side_left  = timeout_left ?
        sonar_pkg::echo_count_t'(sonar_pkg::ECHO_COUNT_MAX) : count_left;
    assign side_right = timeout_right ?
        sonar_pkg::echo_count_t'(sonar_pkg::ECHO_COUNT_MAX) : count_right;

    assign nearest_next = (side_left < side_right) ? side_left : side_right;

    assign hit_left  = !timeout_left &&
        (count_left < sonar_pkg::echo_count_t'(alert_pkg::NEAR_THRESHOLD));
    assign hit_right = !timeout_right &&
        (count_right < sonar_pkg::echo_count_t'(alert_pkg::NEAR_THRESHOLD));

    // Streak restarts on a clear round, saturates at the alarm level
    always_comb begin
        if (!(hit_left || hit_right)) begin
            streak_next = '0;
        end else if (streak >= alert_pkg::streak_t'(alert_pkg::ALARM_ROUNDS)) begin
            streak_next = streak;
        end else begin
            streak_next = streak + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            alert_pkg::IDLE: begin
                if (host_req) begin
                    state_next = alert_pkg::RANGING;
                end
            end
            alert_pkg::RANGING: begin
                if (both_ack) begin
                    state_next = alert_pkg::RELEASE;
                end
            end
            alert_pkg::RELEASE: begin
                if (both_idle) begin
                    state_next = alert_pkg::REPORT;
                end
            end
            alert_pkg::REPORT: begin
                if (!host_req) begin
                    state_next = alert_pkg::IDLE;
                end
            end
            default: begin
                state_next = alert_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= alert_pkg::IDLE;
            meas_req <= 1'b0;
            host_ack <= 1'b0;
            streak   <= '0;
            alarm    <= 1'b0;
        end else begin
            state    <= state_next;
            meas_req <= (state_next == alert_pkg::RANGING);
            host_ack <= (state_next == alert_pkg::REPORT);
            if (latch_en) begin
                streak <= streak_next;
                alarm  <= (streak_next >= alert_pkg::streak_t'(alert_pkg::ALARM_ROUNDS));
            end
        end
    end

    // Round results, held until the next round completes
    always_ff @(posedge clk) begin
        if (latch_en) begin
            nearest_count <= nearest_next;
            near_left     <= hit_left;
            near_right    <= hit_right;
        end
    end

endmodule

`default_nettype wire

// File: rtl/obstacle_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module obstacle_monitor_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   host_req,
    output logic                   host_ack,
    input  logic                   echo_left,
    input  logic                   echo_right,
    output logic                   trigger_left,
    output logic                   trigger_right,
    output sonar_pkg::echo_count_t nearest_count,
    output logic                   near_left,
    output logic                   near_right,
    output logic                   alarm
);

    logic meas_req;   // Shared by both rangers
    logic ack_left;
    logic ack_right;
    logic timeout_left;
    logic timeout_right;

    sonar_pkg::echo_count_t count_left;
    sonar_pkg::echo_count_t count_right;

    echo_ranger ranger_left (
        .clk        (clk),
        .reset_n    (reset_n),
        .meas_req   (meas_req),
        .echo       (echo_left),
        .meas_ack   (ack_left),
        .trigger    (trigger_left),
        .echo_count (count_left),
        .timed_out  (timeout_left)
    );

    echo_ranger ranger_right (
        .clk        (clk),
        .reset_n    (reset_n),
        .meas_req   (meas_req),
        .echo       (echo_right),
        .meas_ack   (ack_right),
        .trigger    (trigger_right),
        .echo_count (count_right),
        .timed_out  (timeout_right)
    );

    proximity_judge judge (
        .clk           (clk),
        .reset_n       (reset_n),
        .host_req      (host_req),
        .host_ack      (host_ack),
        .meas_req      (meas_req),
        .ack_left      (ack_left),
        .ack_right     (ack_right),
        .count_left    (count_left),
        .count_right   (count_right),
        .timeout_left  (timeout_left),
        .timeout_right (timeout_right),
        .nearest_count (nearest_count),
        .near_left     (near_left),
        .near_right    (near_right),
        .alarm         (alarm)
    );

endmodule

`default_nettype wire

// File: testbench/sonar_echo_model.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_echo_model (
    input  logic clk,
    input  logic trigger,
    input  int   delay_cycles,   // Cycles from trigger fall to echo rise
    input  int   width,          // Echo high time in cycles
    input  logic silent,         // No echo at all
    output logic echo
);

    localparam int DRIVE_DELAY = 2;

    // Answer every trigger pulse with one echo
    initial begin
        echo = 1'b0;
        forever begin
            @(posedge trigger);
            @(negedge trigger);
            if (!silent) begin
                repeat (delay_cycles) begin
                    @(posedge clk);
                end
                #DRIVE_DELAY echo = 1'b1;
                repeat (width) begin
                    @(posedge clk);
                end
                #DRIVE_DELAY echo = 1'b0;   // Sampled high on exactly width edges
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_obstacle_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_obstacle_monitor;

    localparam int DRIVE_DELAY  = 2;
    localparam int N_DIRECTED   = 15;
    localparam int N_RANDOM     = 40;
    localparam int MAX_WIDTH    = 600;
    localparam int ROUND_CYCLES = sonar_pkg::TRIG_CYCLES + sonar_pkg::ECHO_WAIT_LIMIT +
                                  MAX_WIDTH + 20;
    localparam int CYCLE_LIMIT  = (N_DIRECTED + N_RANDOM) * ROUND_CYCLES + 20;

    logic clk;
    logic reset_n;
    logic host_req;
    logic host_ack;
    logic echo_left;
    logic echo_right;
    logic trigger_left;
    logic trigger_right;
    logic near_left;
    logic near_right;
    logic alarm;

    sonar_pkg::echo_count_t nearest_count;

    // Programmed echo per side, read by models and the compare process
    int   width_l;
    int   width_r;
    int   delay_l;
    int   delay_r;
    logic silent_l;
    logic silent_r;

    int errors;
    int rounds_checked;
    int streak_model;   // Reference streak across rounds
    int cycle_count;
    int seed;
    int hold_cycles;

    obstacle_monitor_top dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .host_req      (host_req),
        .host_ack      (host_ack),
        .echo_left     (echo_left),
        .echo_right    (echo_right),
        .trigger_left  (trigger_left),
        .trigger_right (trigger_right),
        .nearest_count (nearest_count),
        .near_left     (near_left),
        .near_right    (near_right),
        .alarm         (alarm)
    );

    sonar_echo_model model_left (
        .clk          (clk),
        .trigger      (trigger_left),
        .delay_cycles (delay_l),
        .width        (width_l),
        .silent       (silent_l),
        .echo         (echo_left)
    );

    sonar_echo_model model_right (
        .clk          (clk),
        .trigger      (trigger_right),
        .delay_cycles (delay_r),
        .width        (width_r),
        .silent       (silent_r),
        .echo         (echo_right)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic void expected_result(
        input  int   w_l,
        input  logic s_l,
        input  int   w_r,
        input  logic s_r,
        input  int   streak_prev,
        output int   nearest,
        output logic near_l,
        output logic near_r,
        output logic alarm_exp,
        output int   streak_new
    );
        int side_l;
        int side_r;
        // A silent side reads as the farthest possible count
        side_l = s_l ? sonar_pkg::ECHO_COUNT_MAX : w_l;
        side_r = s_r ? sonar_pkg::ECHO_COUNT_MAX : w_r;
        nearest = (side_l < side_r) ? side_l : side_r;
        near_l = !s_l && (w_l < alert_pkg::NEAR_THRESHOLD);
        near_r = !s_r && (w_r < alert_pkg::NEAR_THRESHOLD);
        if (near_l || near_r) begin
            streak_new = (streak_prev >= alert_pkg::ALARM_ROUNDS) ?
                alert_pkg::ALARM_ROUNDS : streak_prev + 1;
        end else begin
            streak_new = 0;
        end
        alarm_exp = (streak_new >= alert_pkg::ALARM_ROUNDS);
    endfunction

    // Compare every round when the judge acknowledges
    initial begin
        int   exp_nearest;
        int   exp_streak;
        logic exp_near_l;
        logic exp_near_r;
        logic exp_alarm;
        forever begin
            @(posedge host_ack);
            expected_result(width_l, silent_l, width_r, silent_r, streak_model,
                            exp_nearest, exp_near_l, exp_near_r, exp_alarm, exp_streak);
            compare_value("nearest_count", nearest_count, exp_nearest);
            compare_value("near_left", near_left, exp_near_l);
            compare_value("near_right", near_right, exp_near_r);
            compare_value("alarm", alarm, exp_alarm);
            compare_value("count_left", dut.count_left, silent_l ? 0 : width_l);
            compare_value("count_right", dut.count_right, silent_r ? 0 : width_r);
            compare_value("timeout_left", dut.timeout_left, silent_l);
            compare_value("timeout_right", dut.timeout_right, silent_r);
            streak_model = exp_streak;
            rounds_checked++;
        end
    end

    // Both triggers start together from the shared meas_req
    initial begin
        int len_l;
        int len_r;
        forever begin
            @(posedge trigger_left);
            #DRIVE_DELAY;
            len_l = 0;
            len_r = 0;
            while (trigger_left || trigger_right) begin
                len_l += int'(trigger_left);
                len_r += int'(trigger_right);
                @(posedge clk);
                #DRIVE_DELAY;
            end
            compare_value("trigger_left width", len_l, sonar_pkg::TRIG_CYCLES);
            compare_value("trigger_right width", len_r, sonar_pkg::TRIG_CYCLES);
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a req/ack handshake stalled", cycle_count);
        errors++;
        $display("Errors: %0d", errors);
        $display("TEST FAIL");
        $finish;
    end

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic host_handshake(input int hold);
        host_req = 1'b1;
        do begin
            step_cycle();
        end while (!host_ack);
        repeat (hold) begin
            step_cycle();
            compare_value("trigger_left", trigger_left, 0);   // Rangers stay idle
            compare_value("trigger_right", trigger_right, 0);
        end
        host_req = 1'b0;
        do begin
            step_cycle();
        end while (host_ack);
    endtask

    task automatic run_round(input int w_l, input logic s_l, input int w_r, input logic s_r,
                             input int d_l, input int d_r, input int hold);
        width_l  = w_l;
        silent_l = s_l;
        width_r  = w_r;
        silent_r = s_r;
        delay_l  = d_l;
        delay_r  = d_r;
        host_handshake(hold);
    endtask

    initial begin
        errors         = 0;
        rounds_checked = 0;
        streak_model   = 0;
        seed           = 69739;
        reset_n        = 1'b1;   // Reset is active high
        host_req       = 1'b0;
        width_l        = 1;
        width_r        = 1;
        delay_l        = 1;
        delay_r        = 1;
        silent_l       = 1'b1;
        silent_r       = 1'b1;
        repeat (5) begin
            @(posedge clk);
        end
        #DRIVE_DELAY reset_n = 1'b0;
        step_cycle();
        step_cycle();
        compare_value("host_ack", host_ack, 0);
        compare_value("alarm", alarm, 0);
        compare_value("trigger_left", trigger_left, 0);
        compare_value("trigger_right", trigger_right, 0);

        // Fixed widths, nearer side wins
        run_round(120, 1'b0, 250, 1'b0, 5, 17, 2);
        run_round(480, 1'b0, 90, 1'b0, 5, 17, 2);
        // Silent sides
        run_round(0, 1'b1, 200, 1'b0, 5, 17, 2);
        run_round(350, 1'b0, 0, 1'b1, 5, 17, 2);
        run_round(0, 1'b1, 0, 1'b1, 5, 17, 2);
        // Around the near threshold
        run_round(alert_pkg::NEAR_THRESHOLD - 1, 1'b0, alert_pkg::NEAR_THRESHOLD + 1, 1'b0,
                  5, 17, 2);
        run_round(alert_pkg::NEAR_THRESHOLD + 1, 1'b0, alert_pkg::NEAR_THRESHOLD - 1, 1'b0,
                  5, 17, 2);
        run_round(alert_pkg::NEAR_THRESHOLD - 1, 1'b0, alert_pkg::NEAR_THRESHOLD - 1, 1'b0,
                  5, 17, 2);
        run_round(alert_pkg::NEAR_THRESHOLD, 1'b0, alert_pkg::NEAR_THRESHOLD, 1'b0, 5, 17, 2);
        // Alarm streak, then one clear round
        run_round(500, 1'b0, 500, 1'b0, 5, 17, 2);
        repeat (4) begin
            run_round(100, 1'b0, 500, 1'b0, 5, 17, 2);
        end
        run_round(500, 1'b0, 500, 1'b0, 5, 17, 2);

        for (int i = 0; i < N_RANDOM; i++) begin
            hold_cycles = ($unsigned($random(seed)) % 4 == 0) ?
                100 + $unsigned($random(seed)) % 100 : $unsigned($random(seed)) % 4;
            run_round(1 + $unsigned($random(seed)) % MAX_WIDTH,
                      $unsigned($random(seed)) % 5 == 0,
                      1 + $unsigned($random(seed)) % MAX_WIDTH,
                      $unsigned($random(seed)) % 5 == 0,
                      1 + $unsigned($random(seed)) % 60,
                      1 + $unsigned($random(seed)) % 60,
                      hold_cycles);
        end

        step_cycle();
        step_cycle();
        if (rounds_checked != N_DIRECTED + N_RANDOM) begin
            $display("Only %0d of %0d rounds were checked", rounds_checked,
                     N_DIRECTED + N_RANDOM);
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/sonar_pkg.sv
rtl/alert_pkg.sv
rtl/echo_ranger.sv
rtl/proximity_judge.sv
rtl/obstacle_monitor_top.sv
testbench/sonar_echo_model.sv
testbench/tb_obstacle_monitor.sv

// File: Makefile
# Verilator simulation of the obstacle monitor

VERILATOR ?= verilator
TOP       ?= tb_obstacle_monitor
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
